// File: tb.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/line_memory.sv
rtl/cache_top.sv
bench/cache_tb.sv

// File: bench/cache_tb.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int N_RANDOM    = 300;
    localparam int N_DIRECTED  = 20;
    // a dirty miss costs two bus transactions plus the idle cycles around them.
    localparam int MISS_CYCLES = 2 * (`MEM_LATENCY + 3) + 4;
    localparam int MAX_CYCLES  = (N_DIRECTED + N_RANDOM) * MISS_CYCLES + 100;
    localparam int MEM_WORDS   = (1 << `ADDR_WIDTH) / (`DATA_WIDTH / 8);

    logic                   clk;
    logic                   n_rst;
    cpu_req_t               req;
    cpu_rsp_t               rsp;
    logic [`DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    logic [31:0]            lfsr_q;
    string                  test_name;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycle_count = 0;
    int                     busy_cycles;
    int                     xfers;

    cache_top u_dut (
        .clk   (clk),
        .n_rst (n_rst),
        .i_req (req),
        .o_rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected read value is the last word written there, or zero.
    function automatic logic [`DATA_WIDTH-1:0] ref_read(input logic [`ADDR_WIDTH-1:0] addr);
        return ref_mem[addr >> 2];
    endfunction

    // fibonacci lfsr with taps 32, 22, 2 and 1.
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // holds the request until it is accepted and counts busy cycles and bus done pulses.
    task automatic access(
        input logic                   write,
        input logic [`ADDR_WIDTH-1:0] addr,
        input logic [`DATA_WIDTH-1:0] data
    );
        logic accepted;
        req.re      = !write;
        req.we      = write;
        req.addr    = addr;
        req.wdata   = data;
        busy_cycles = 0;
        xfers       = 0;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (rsp.busy) begin
                busy_cycles++;
            end
            if (u_dut.biu_rsp.done) begin
                xfers++;
            end
            accepted = rsp.hit && !rsp.busy;
        end
        if (write) begin
            ref_mem[addr >> 2] = data;
        end
        @(posedge clk);
        #10;
    endtask

    always @(negedge clk) begin
        if (n_rst && req.re && rsp.hit && !rsp.busy) begin
            check_value(test_name, ref_read(req.addr), rsp.rdata);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no response after %0d cycles in test %s", cycle_count, test_name);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int                     i;
        logic [5:0]             w;
        logic                   wr;
        logic [`DATA_WIDTH-1:0] data;
        logic [`ADDR_WIDTH-1:0] addr;
        n_rst     = 1'b0;
        req       = '0;
        lfsr_q    = 32'hcd8c;
        test_name = "reset";
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        #10;
        n_rst = 1'b1;

        test_name = "reset_idle";
        repeat (5) begin
            @(negedge clk);
            check_value("reset_idle_busy", 0, rsp.busy);
            check_value("reset_idle_en", 0, u_dut.biu_req.en);
        end
        @(posedge clk);
        #10;

        test_name = "cold_read";
        access(1'b0, 12'h048, '0);
        check_value("cold_read_xfers", 1, xfers);
        test_name = "line_hit";
        for (i = 0; i < 4; i++) begin
            if (i != 2) begin
                access(1'b0, 12'h040 + 4 * i, '0);
                check_value("line_hit_busy", 0, busy_cycles);
            end
        end

        test_name = "write_hit";
        access(1'b1, 12'h044, 32'ha5a5_1234);
        check_value("write_hit_busy", 0, busy_cycles);
        for (i = 0; i < 4; i++) begin
            access(1'b0, 12'h040 + 4 * i, '0);
        end

        // same index as the dirty line at 0x040 with another tag.
        test_name = "evict_dirty";
        access(1'b0, 12'h440, '0);
        check_value("evict_dirty_xfers", 2, xfers);
        test_name = "reread_victim";
        access(1'b0, 12'h044, '0);
        check_value("reread_victim_xfers", 1, xfers);

        test_name = "random";
        for (i = 0; i < N_RANDOM; i++) begin
            w    = random_bits(6);
            wr   = random_bits(1);
            data = random_bits(32);
            addr = (w[5] ? 12'h300 : 12'h000) + {w[4:0], 2'b00};
            access(wr, addr, data);
        end
        req = '0;
        repeat (2) @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                clk,
    input  logic                n_rst,
    input  cache_pkg::cpu_req_t i_req,
    output cache_pkg::cpu_rsp_t o_rsp
);

    import cache_pkg::*;

    biu_req_t biu_req;
    biu_rsp_t biu_rsp;

    cache_ctrl u_ctrl (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_req     (i_req),
        .o_rsp     (o_rsp),
        .o_biu_req (biu_req),
        .i_biu_rsp (biu_rsp)
    );

    line_memory u_mem (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_biu_req (biu_req),
        .o_biu_rsp (biu_rsp)
    );

endmodule

// File: rtl/line_memory.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module line_memory (
    input  logic                clk,
    input  logic                n_rst,
    input  cache_pkg::biu_req_t i_biu_req,
    output cache_pkg::biu_rsp_t o_biu_rsp
);

    import cache_pkg::*;

    localparam int LINES = 2**(`ADDR_WIDTH - OFFSET_WIDTH);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [LINE_WIDTH-1:0]    mem_q [LINES];
    logic [LINE_WIDTH-1:0]    rdata_q;
    logic [CNT_W-1:0]         cnt_q;
    logic                     busy_q;
    logic                     done_q;
    logic                     start;
    logic                     finish;
    addr_fields_t             addr;
    logic [$clog2(LINES)-1:0] line_sel;

    assign addr     = addr_fields_t'(i_biu_req.addr);
    assign line_sel = {addr.tag, addr.index};

    // a request still held during done is the one just served.
    assign start  = i_biu_req.en && !busy_q && !done_q;
    assign finish = busy_q && (cnt_q == CNT_W'(1));

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= finish;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (finish) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            for (int i = 0; i < LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (done_q && i_biu_req.en && i_biu_req.we) begin
            mem_q[line_sel] <= i_biu_req.data;
        end
    end

    // read data is ready in the done cycle.
    always_ff @(posedge clk) begin
        if (finish && !i_biu_req.we) begin
            rdata_q <= mem_q[line_sel];
        end
    end

    always_comb begin
        o_biu_rsp.done = done_q;
        o_biu_rsp.busy = busy_q;
        o_biu_rsp.data = rdata_q;
    end

    a_addr_stable : assert property (
        @(posedge clk) disable iff (~n_rst)
        busy_q |-> $stable(i_biu_req.addr)
    );

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
    input  logic                clk,
    input  logic                n_rst,
    input  cache_pkg::cpu_req_t i_req,
    output cache_pkg::cpu_rsp_t o_rsp,
    output cache_pkg::biu_req_t o_biu_req,
    input  cache_pkg::biu_rsp_t i_biu_rsp
);

    import cache_pkg::*;

    ctrl_state_t              state_q;
    ctrl_state_t              state_d;
    addr_fields_t             req_addr;
    addr_fields_t             miss_addr;
    addr_fields_t             vaddr_q;
    logic [LINE_WIDTH-1:0]    vdata_q;
    logic [`DATA_WIDTH-1:0]   cache_rdata;
    logic [LINE_WIDTH-1:0]    cache_vdata;
    logic [TAG_WIDTH-1:0]     cache_tag;
    logic                     cache_hit;
    logic                     cache_dirty;
    logic                     cache_we;
    logic                     cache_fe;
    logic                     done_q;

    assign req_addr  = addr_fields_t'(i_req.addr);
    assign miss_addr = '{tag: req_addr.tag, index: req_addr.index, offset: '0};

    // done in VICTIM ends the write back and must not refill the line.
    assign cache_fe = i_biu_rsp.done && (state_q == MISS);
    assign cache_we = i_req.we && (state_q != VICTIM);

    // the old line is still in the array on the fill edge.
    always_ff @(posedge clk) begin
        if (cache_fe && cache_dirty) begin
            vdata_q <= cache_vdata;
            vaddr_q <= '{tag: cache_tag, index: req_addr.index, offset: '0};
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= i_biu_rsp.done;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if ((i_req.re || i_req.we) && !cache_hit) begin
                    state_d = MISS;
                end
            end
            MISS: begin
                if (i_biu_rsp.done) begin
                    state_d = cache_dirty ? VICTIM : IDLE;
                end
            end
            VICTIM: begin
                if (i_biu_rsp.done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // enable drops for one cycle after every done.
    always_comb begin
        o_rsp.rdata    = cache_rdata;
        o_rsp.hit      = cache_hit;
        o_rsp.busy     = state_q != IDLE;
        o_biu_req.en   = (state_q != IDLE) && !done_q;
        o_biu_req.we   = state_q == VICTIM;
        o_biu_req.addr = (state_q == VICTIM) ? vaddr_q : miss_addr;
        o_biu_req.data = vdata_q;
    end

    cache_array u_array (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_re    (i_req.re),
        .i_we    (cache_we),
        .i_fe    (cache_fe),
        .i_addr  (req_addr),
        .i_wdata (i_req.wdata),
        .i_fdata (i_biu_rsp.data),
        .o_hit   (cache_hit),
        .o_dirty (cache_dirty),
        .o_tag   (cache_tag),
        .o_vdata (cache_vdata),
        .o_rdata (cache_rdata)
    );

    // the memory is quiet whenever the controller is idle.
    a_bus_idle : assert property (
        @(posedge clk) disable iff (~n_rst)
        (state_q == IDLE) |-> !(i_biu_rsp.busy || i_biu_rsp.done)
    );

    // the done that ends VICTIM has to meet the write back still on the bus.
    a_victim_write : assert property (
        @(posedge clk) disable iff (~n_rst)
        (state_q == VICTIM && i_biu_rsp.done) |-> o_biu_req.en
    );

endmodule

// File: rtl/cache_array.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_array (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             i_re,
    input  logic                             i_we,
    input  logic                             i_fe,
    input  cache_pkg::addr_fields_t          i_addr,
    input  logic [`DATA_WIDTH-1:0]           i_wdata,
    input  logic [cache_pkg::LINE_WIDTH-1:0] i_fdata,
    output logic                             o_hit,
    output logic                             o_dirty,
    output logic [cache_pkg::TAG_WIDTH-1:0]  o_tag,
    output logic [cache_pkg::LINE_WIDTH-1:0] o_vdata,
    output logic [`DATA_WIDTH-1:0]           o_rdata
);

    import cache_pkg::*;

    localparam int LINES = 2**INDEX_WIDTH;
    localparam int WORDS = 2**WORD_SEL_WIDTH;

    logic [TAG_WIDTH-1:0]              tag_q  [LINES];
    logic [WORDS-1:0][`DATA_WIDTH-1:0] data_q [LINES];
    logic [LINES-1:0]                  valid_q;
    logic [LINES-1:0]                  dirty_q;
    logic [WORD_SEL_WIDTH-1:0]         word_sel;
    logic                              tag_match;
    logic                              write_hit;

    // the low offset bits select a byte inside the word and are ignored.
    assign word_sel  = i_addr.offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
    assign tag_match = valid_q[i_addr.index] && (tag_q[i_addr.index] == i_addr.tag);
    assign o_hit     = (i_re || i_we) && tag_match;
    assign write_hit = i_we && o_hit;

    // the indexed entry is also what gets evicted on a miss.
    assign o_dirty = dirty_q[i_addr.index];
    assign o_tag   = tag_q[i_addr.index];
    assign o_vdata = data_q[i_addr.index];
    assign o_rdata = data_q[i_addr.index][word_sel];

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fe) begin
            valid_q[i_addr.index] <= 1'b1;
            dirty_q[i_addr.index] <= 1'b0;
        end else if (write_hit) begin
            dirty_q[i_addr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fe) begin
            tag_q[i_addr.index]  <= i_addr.tag;
            data_q[i_addr.index] <= i_fdata;
        end else if (write_hit) begin
            data_q[i_addr.index][word_sel] <= i_wdata;
        end
    end

    // a fill only happens on a miss, so it can never meet a write hit.
    a_fill_write_excl : assert property (
        @(posedge clk) disable iff (~n_rst)
        i_fe |-> !write_hit
    );

endmodule

// File: rtl/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    localparam int OFFSET_WIDTH   = $clog2(`CACHE_LINE_SIZE);
    localparam int INDEX_WIDTH    = $clog2(`CACHE_SIZE / `CACHE_LINE_SIZE);
    localparam int TAG_WIDTH      = `ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH     = `CACHE_LINE_SIZE * 8;
    localparam int WORD_SEL_WIDTH = $clog2(LINE_WIDTH / `DATA_WIDTH);

    typedef struct packed {
        logic                   re;
        logic                   we;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] rdata;
        logic                   hit;
        logic                   busy;
    } cpu_rsp_t;

    // the address on the bus is always line aligned.
    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]  data;
    } biu_req_t;

    typedef struct packed {
        logic                   done;
        logic                   busy;
        logic [LINE_WIDTH-1:0]  data;
    } biu_rsp_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } addr_fields_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        MISS   = 2'b01,
        VICTIM = 2'b10
    } ctrl_state_t;

endpackage

// File: rtl/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// width of one processor word in bits.
`define DATA_WIDTH 32

// byte address width of the processor port and the bus.
`define ADDR_WIDTH 12

// total cache capacity in bytes.
`define CACHE_SIZE 256

// one line holds four words.
`define CACHE_LINE_SIZE 16

// cycles from a bus request to its done pulse.
`define MEM_LATENCY 4

`endif
